/* design/clock_pkg.sv */
`default_nettype none

package clock_pkg;

	// --------------------------------------------------
	// field layout
	// --------------------------------------------------
	localparam int NUM_FIELDS = 3;	// seconds, minutes, hours

	// wide enough for 0..59
	typedef logic [5:0] time_val_t;

	// last value of each field, indexed like pos_e
	localparam time_val_t FIELD_MAX [NUM_FIELDS] = '{
		6'd59,	// seconds
		6'd59,	// minutes
		6'd23	// hours
	};

	// --------------------------------------------------
	// controller state
	// --------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK,	// normal running
		MODE_SETUP,	// clock stopped, set steps time
		MODE_ALARM	// alarm shown, set steps alarm
	} mode_e;

	// value doubles as the field index
	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} pos_e;

endpackage

`default_nettype wire

/* design/seg_pkg.sv */
`default_nettype none

package seg_pkg;

	localparam int NUM_DIGITS = 6;

	typedef logic [3:0] bcd_t;	// one decimal digit
	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}, 1 lights the segment
	typedef logic [5:0] enb_t;	// digit enables, active low

	// --------------------------------------------------
	// segment patterns for 0..9
	// --------------------------------------------------
	localparam seg_t SEG_CODE [10] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011	// 9
	};

	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage

`default_nettype wire

/* design/field_if.sv */
`default_nettype none

// one per time field, set strobes in and values out
interface field_if;

	logic                 set_time;	// step the time counter once
	logic                 set_alarm;	// step the alarm counter once
	clock_pkg::time_val_t time_val;
	clock_pkg::time_val_t alarm_val;
	logic                 match;	// time equals alarm

	modport ctrl (
		output set_time,
		output set_alarm,
		input  match
	);

	modport field (
		input  set_time,
		input  set_alarm,
		output time_val,
		output alarm_val,
		output match
	);

	modport disp (
		input time_val,
		input alarm_val
	);

endinterface

`default_nettype wire

/* design/tick_gen.sv */
`default_nettype none

module tick_gen #(
	parameter int P_CLK_PER_SEC    = 50_000_000,
	parameter int P_CLK_PER_SCAN   = 5_000,
	parameter int P_CLK_PER_SAMPLE = 500_000
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_sample_tick,
	output logic o_blink_on
);

	// divider period for each rate, the last one is the blink quarter second
	function automatic int unsigned tick_period(input int idx);
		case (idx)
			0:       return P_CLK_PER_SEC;
			1:       return P_CLK_PER_SCAN;
			2:       return P_CLK_PER_SAMPLE;
			default: return (P_CLK_PER_SEC >= 4) ? P_CLK_PER_SEC / 4 : 1;
		endcase
	endfunction

	wire [3:0] tick;	// sec, scan, sample, blink

	// --------------------------------------------------
	// down-counters, pulse on reload
	// --------------------------------------------------
	for (genvar g = 0; g < 4; g++) begin : g_div
		logic [31:0] cnt;
		logic        tick_q;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt    <= 32'(tick_period(g) - 1);
				tick_q <= 1'b0;
			end else if (cnt == '0) begin
				cnt    <= 32'(tick_period(g) - 1);
				tick_q <= 1'b1;
			end else begin
				cnt    <= cnt - 1'b1;
				tick_q <= 1'b0;
			end
		end

		assign tick[g] = tick_q;
	end

	// blink phase, starts lit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_blink_on <= 1'b1;
		end else if (tick[3]) begin
			o_blink_on <= ~o_blink_on;
		end
	end

	assign o_sec_tick    = tick[0];
	assign o_scan_tick   = tick[1];
	assign o_sample_tick = tick[2];

endmodule

`default_nettype wire

/* design/mode_ctrl.sv */
`default_nettype none

module mode_ctrl import clock_pkg::*; (
	input  wire   clk,
	input  wire   rst_n,
	input  wire   i_sample_tick,
	input  wire   i_mode_btn,
	input  wire   i_pos_btn,
	input  wire   i_set_btn,
	input  wire   i_alarm_btn,
	output mode_e o_mode,
	output pos_e  o_pos,
	output logic  o_run,
	output logic  o_alarm,
	field_if.ctrl fld [NUM_FIELDS]
);

	logic [3:0]            btn_raw;
	logic [3:0]            btn_smp;	// level seen at the last sample tick
	logic [3:0]            press_q;
	logic                  mode_press;
	logic                  pos_press;
	logic                  set_press;
	logic                  alarm_press;
	logic                  alarm_en;
	logic [NUM_FIELDS-1:0] set_time_q;
	logic [NUM_FIELDS-1:0] set_alarm_q;
	logic [NUM_FIELDS-1:0] match;

	// --------------------------------------------------
	// button sampling and rising edge detect
	// --------------------------------------------------
	assign btn_raw = {i_alarm_btn, i_set_btn, i_pos_btn, i_mode_btn};

	// a button must be held over two sample ticks to be seen reliably
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_smp <= '0;
			press_q <= '0;
		end else if (i_sample_tick) begin
			btn_smp <= btn_raw;
			press_q <= btn_raw & ~btn_smp;	// high now, low last time
		end else begin
			press_q <= '0;
		end
	end

	assign {alarm_press, set_press, pos_press, mode_press} = press_q;

	// --------------------------------------------------
	// mode and position
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (mode_press) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pos <= POS_SEC;
		end else if (pos_press) begin
			case (o_pos)
				POS_SEC: o_pos <= POS_MIN;
				POS_MIN: o_pos <= POS_HR;
				default: o_pos <= POS_SEC;
			endcase
		end
	end

	assign o_run = (o_mode != MODE_SETUP);	// time stops only in setup

	// set strobes, one cycle each, to the selected field
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			set_time_q  <= '0;
			set_alarm_q <= '0;
		end else begin
			set_time_q  <= '0;
			set_alarm_q <= '0;
			if (set_press && o_mode == MODE_SETUP)
				set_time_q[o_pos] <= 1'b1;
			if (set_press && o_mode == MODE_ALARM)
				set_alarm_q[o_pos] <= 1'b1;
		end
	end

	// --------------------------------------------------
	// alarm enable and latch
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_en <= 1'b0;
			o_alarm  <= 1'b0;
		end else begin
			if (alarm_press)
				alarm_en <= ~alarm_en;
			o_alarm <= alarm_en & (o_alarm | (&match));	// hold until disabled
		end
	end

	for (genvar g = 0; g < NUM_FIELDS; g++) begin : g_fld
		assign fld[g].set_time  = set_time_q[g];
		assign fld[g].set_alarm = set_alarm_q[g];
		assign match[g]         = fld[g].match;
	end

	// only one counter in the whole clock may be stepped by hand per cycle
	a_one_set: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({set_time_q, set_alarm_q}));

endmodule

`default_nettype wire

/* design/time_field.sv */
`default_nettype none

module time_field import clock_pkg::*; #(
	parameter int P_INDEX = 0
) (
	input  wire    clk,
	input  wire    rst_n,
	input  wire    i_step,
	input  wire    i_run,
	output logic   o_carry,
	field_if.field fld
);

	time_val_t time_q;
	time_val_t alarm_q;
	logic      run_step;

	// next count with wrap after this field's limit
	function automatic time_val_t next_val(input time_val_t v);
		return (v >= FIELD_MAX[P_INDEX]) ? '0 : v + 1'b1;
	endfunction

	assign run_step = i_step & i_run;
	assign o_carry  = run_step && (time_q == FIELD_MAX[P_INDEX]);	// hand set never carries

	// --------------------------------------------------
	// time and alarm counters
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q <= '0;
		end else if (run_step || fld.set_time) begin
			time_q <= next_val(time_q);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= '0;
		end else if (fld.set_alarm) begin
			alarm_q <= next_val(alarm_q);
		end
	end

	assign fld.time_val  = time_q;
	assign fld.alarm_val = alarm_q;
	assign fld.match     = (time_q == alarm_q);

	// both counters stay inside the field range, through carries and hand sets
	a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(time_q <= FIELD_MAX[P_INDEX]) && (alarm_q <= FIELD_MAX[P_INDEX]));

endmodule

`default_nettype wire

/* design/display_scan.sv */
`default_nettype none

module display_scan import clock_pkg::*, seg_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        i_scan_tick,
	input  wire        i_blink_on,
	input  wire mode_e i_mode,
	input  wire pos_e  i_pos,
	output seg_t       o_seg,
	output enb_t       o_seg_enb,
	field_if.disp      fld [NUM_FIELDS]
);

	logic [2:0] dig_q;	// digit being driven, 0..5
	logic [1:0] fld_sel;
	time_val_t  shown [NUM_FIELDS];
	time_val_t  val;
	bcd_t       ones;
	bcd_t       tens;
	bcd_t       digit;
	logic       blank;

	// --------------------------------------------------
	// digit scan counter
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dig_q <= '0;
		end else if (i_scan_tick) begin
			if (dig_q == 3'(NUM_DIGITS - 1))
				dig_q <= '0;
			else
				dig_q <= dig_q + 1'b1;
		end
	end

	// alarm mode shows the alarm setting
	for (genvar g = 0; g < NUM_FIELDS; g++) begin : g_val
		assign shown[g] = (i_mode == MODE_ALARM) ? fld[g].alarm_val : fld[g].time_val;
	end

	// --------------------------------------------------
	// digit select and BCD split
	// --------------------------------------------------
	assign fld_sel = dig_q[2:1];	// two digits per field
	assign val     = shown[fld_sel];
	assign ones    = bcd_t'(val % 10);
	assign tens    = bcd_t'(val / 10);
	assign digit   = dig_q[0] ? tens : ones;	// odd digit is the tens

	// selected field flashes while being set
	assign blank = (i_mode != MODE_CLOCK) && !i_blink_on && (fld_sel == i_pos);

	// --------------------------------------------------
	// segment decode and enable
	// --------------------------------------------------
	always_comb begin
		if (blank)
			o_seg = SEG_BLANK;
		else
			o_seg = SEG_CODE[digit];
	end

	assign o_seg_enb = ~(enb_t'(1) << dig_q);

	// scanning never lights two digits or none
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

`default_nettype wire

/* design/clock_top.sv */
`default_nettype none

module clock_top import clock_pkg::*, seg_pkg::*; #(
	parameter int P_CLK_PER_SEC    = 50_000_000,
	parameter int P_CLK_PER_SCAN   = 5_000,
	parameter int P_CLK_PER_SAMPLE = 500_000
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  i_mode_btn,
	input  wire  i_pos_btn,
	input  wire  i_set_btn,
	input  wire  i_alarm_btn,
	output seg_t o_seg,
	output enb_t o_seg_enb,
	output logic o_alarm
);

	logic                 sec_tick;
	logic                 scan_tick;
	logic                 sample_tick;
	logic                 blink_on;
	mode_e                mode;
	pos_e                 pos;
	logic                 run;
	wire [NUM_FIELDS-1:0] carry;
	wire [NUM_FIELDS-1:0] step;

	field_if fld_bus [NUM_FIELDS] ();

	tick_gen #(
		.P_CLK_PER_SEC    (P_CLK_PER_SEC),
		.P_CLK_PER_SCAN   (P_CLK_PER_SCAN),
		.P_CLK_PER_SAMPLE (P_CLK_PER_SAMPLE)
	) u_tick_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_scan_tick   (scan_tick),
		.o_sample_tick (sample_tick),
		.o_blink_on    (blink_on)
	);

	mode_ctrl u_mode_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_mode_btn    (i_mode_btn),
		.i_pos_btn     (i_pos_btn),
		.i_set_btn     (i_set_btn),
		.i_alarm_btn   (i_alarm_btn),
		.o_mode        (mode),
		.o_pos         (pos),
		.o_run         (run),
		.o_alarm       (o_alarm),
		.fld           (fld_bus)
	);

	// --------------------------------------------------
	// seconds step on the tick, the rest on the carry below
	// --------------------------------------------------
	assign step = {carry[NUM_FIELDS-2:0], sec_tick};

	for (genvar g = 0; g < NUM_FIELDS; g++) begin : g_field
		time_field #(
			.P_INDEX (g)
		) u_time_field (
			.clk     (clk),
			.rst_n   (rst_n),
			.i_step  (step[g]),
			.i_run   (run),
			.o_carry (carry[g]),
			.fld     (fld_bus[g])
		);
	end

	display_scan u_display_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_blink_on  (blink_on),
		.i_mode      (mode),
		.i_pos       (pos),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb),
		.fld         (fld_bus)
	);

endmodule

`default_nettype wire

/* tb/tb_clock_top.sv */
`default_nettype none

module tb_clock_top import clock_pkg::*; ();

	localparam int P_SEC    = 8;
	localparam int P_SCAN   = 2;
	localparam int P_SAMPLE = 4;
	localparam int LIMIT    = 200 * P_SEC;	// cycles allowed for any wait
	localparam int B_MODE   = 0;
	localparam int B_POS    = 1;
	localparam int B_SET    = 2;
	localparam int B_ALARM  = 3;

	// segment patterns a..g for 0..9
	localparam logic [0:9][6:0] SEG_REF = {
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	logic            clk;
	logic            rst_n;
	logic [3:0]      btn;
	logic [6:0]      seg;
	logic [5:0]      seg_enb;
	logic            alarm;

	int              edge_cnt;	// edges since reset release
	int              dig_m;
	logic            blink_m;
	logic [2:0][5:0] tval_m;	// index 0 is seconds
	logic [2:0][5:0] aval_m;
	mode_e           mode_m;
	int              pos_m;
	logic            alarm_en_m;
	logic            set_t_req;
	logic            set_a_req;
	logic            chk_en;	// off while a button is held

	clock_top #(
		.P_CLK_PER_SEC    (P_SEC),
		.P_CLK_PER_SCAN   (P_SCAN),
		.P_CLK_PER_SAMPLE (P_SAMPLE)
	) u_clock_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mode_btn  (btn[B_MODE]),
		.i_pos_btn   (btn[B_POS]),
		.i_set_btn   (btn[B_SET]),
		.i_alarm_btn (btn[B_ALARM]),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic logic [5:0] bump(input logic [5:0] v, input int f);
		return (v == ((f == 2) ? 6'd23 : 6'd59)) ? 6'd0 : v + 6'd1;
	endfunction

	function automatic logic [2:0][5:0] count_up(input logic [2:0][5:0] t);
		logic [2:0][5:0] r;
		logic            c;
		r = t;
		c = 1'b1;
		for (int f = 0; f < 3; f++) begin
			if (c) begin
				r[f] = bump(r[f], f);
				c    = (r[f] == 6'd0);	// carry on wrap only
			end
		end
		return r;
	endfunction

	// 0..9, 10 for blank, 15 for anything else
	function automatic int seg_to_digit(input logic [6:0] s);
		for (int d = 0; d < 10; d++)
			if (s == SEG_REF[d])
				return d;
		return (s == 7'd0) ? 10 : 15;
	endfunction

	function automatic int enb_to_index(input logic [5:0] enb);
		for (int k = 0; k < 6; k++)
			if (!enb[k])
				return k;
		return 0;
	endfunction

	function automatic int expected_digit(input int k, input logic [2:0][5:0] shown,
			input logic blank_phase, input int pos);
		int v;
		v = int'(shown[k / 2]);
		if (blank_phase && (k / 2 == pos))
			return 10;
		return (k % 2 == 1) ? v / 10 : v % 10;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			edge_cnt <= 0;
			dig_m    <= 0;
			blink_m  <= 1'b1;
			tval_m   <= '0;
			aval_m   <= '0;
		end else begin
			edge_cnt <= edge_cnt + 1;
			if (edge_cnt != 0 && edge_cnt % P_SCAN == 0)
				dig_m <= (dig_m == 5) ? 0 : dig_m + 1;
			if (edge_cnt != 0 && edge_cnt % (P_SEC / 4) == 0)
				blink_m <= ~blink_m;
			if (mode_m != MODE_SETUP && edge_cnt != 0 && edge_cnt % P_SEC == 0)
				tval_m <= count_up(tval_m);
			if (set_t_req)
				tval_m[pos_m] <= bump(tval_m[pos_m], pos_m);
			if (set_a_req)
				aval_m[pos_m] <= bump(aval_m[pos_m], pos_m);
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	a_scan: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~seg_enb) && !seg_enb[dig_m])
		else stop_run($sformatf("[FAIL] %0t: digit enable %b, expected digit %0d",
			$time, seg_enb, dig_m));

	a_digit: assert property (@(posedge clk) disable iff (!rst_n)
		chk_en |-> seg_to_digit(seg) == expected_digit(enb_to_index(seg_enb),
			(mode_m == MODE_ALARM) ? aval_m : tval_m,
			(mode_m != MODE_CLOCK) && !blink_m, pos_m))
		else stop_run($sformatf("[FAIL] %0t: digit %0d shows segments %b",
			$time, enb_to_index(seg_enb), seg));

	a_alarm_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(alarm) |-> alarm_en_m && (tval_m == aval_m))
		else stop_run($sformatf("[FAIL] %0t: alarm rose away from the alarm time", $time));

	a_alarm_set: assert property (@(posedge clk) disable iff (!rst_n)
		chk_en && alarm_en_m && (tval_m == aval_m) |=> alarm)
		else stop_run($sformatf("[FAIL] %0t: alarm missed a time match", $time));

	a_alarm_hold: assert property (@(posedge clk) disable iff (!rst_n)
		alarm && alarm_en_m |=> alarm)
		else stop_run($sformatf("[FAIL] %0t: alarm dropped while enabled", $time));

	a_alarm_clear: assert property (@(posedge clk) disable iff (!rst_n)
		chk_en && !alarm_en_m |-> !alarm)
		else stop_run($sformatf("[FAIL] %0t: alarm high while disabled", $time));

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// start two edges into a second so mode changes fall between time steps
	task automatic align_press();
		int n;
		n = 0;
		while (edge_cnt % P_SEC != 2) begin
			if (n > P_SEC)
				stop_run("timeout: press never lined up with the second tick");
			else begin
				n++;
				step();
			end
		end
	endtask

	task automatic press(input int b);
		align_press();
		chk_en = 1'b0;
		btn[b] = 1'b1;
		case (b)
			B_MODE:  mode_m = (mode_m == MODE_CLOCK) ? MODE_SETUP :
			                  (mode_m == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK;
			B_POS:   pos_m = (pos_m == 2) ? 0 : pos_m + 1;
			B_SET: begin
				set_t_req = (mode_m == MODE_SETUP);
				set_a_req = (mode_m == MODE_ALARM);
			end
			default: alarm_en_m = ~alarm_en_m;
		endcase
		step();
		set_t_req = 1'b0;
		set_a_req = 1'b0;
		repeat (3 * P_SAMPLE - 1) step();
		btn[b] = 1'b0;
		chk_en = 1'b1;
		repeat (3 * P_SAMPLE) step();
	endtask

	// step the selected field of the shown counter to target
	task automatic set_to(input int target);
		int n;
		n = 0;
		while (((mode_m == MODE_ALARM) ? aval_m[pos_m] : tval_m[pos_m]) != target) begin
			if (n > 64)
				stop_run($sformatf("timeout: field %0d never reached %0d", pos_m, target));
			else begin
				n++;
				press(B_SET);
			end
		end
	endtask

	task automatic wait_time(input int h, input int m, input int s, input string what);
		int n;
		n = 0;
		while (!(tval_m[2] == h && tval_m[1] == m && tval_m[0] == s)) begin
			if (n > LIMIT)
				stop_run($sformatf("timeout: %s never happened", what));
			else begin
				n++;
				step();
			end
		end
	endtask

	task automatic wait_alarm();
		int n;
		n = 0;
		while (!alarm) begin
			if (n > LIMIT)
				stop_run("timeout: alarm output never went high");
			else begin
				n++;
				step();
			end
		end
	endtask

	initial begin
		btn        = '0;
		rst_n      = 1'b0;
		chk_en     = 1'b0;
		mode_m     = MODE_CLOCK;
		pos_m      = 0;
		alarm_en_m = 1'b0;
		set_t_req  = 1'b0;
		set_a_req  = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n  = 1'b1;
		chk_en = 1'b1;

		wait_time(0, 1, 56, "count to 00:01:56");	// seconds into minutes

		// setup, seconds wrap with no carry, then 23:59:50
		press(B_MODE);
		set_to(0);
		set_to(50);
		press(B_POS);
		set_to(59);
		press(B_POS);
		set_to(23);

		// through alarm mode back to clock, day rollover
		press(B_MODE);
		press(B_MODE);
		wait_time(0, 0, 0, "rollover to 00:00:00");
		wait_time(0, 0, 3, "count past 00:00:00");

		// alarm at 00:02:10
		press(B_MODE);
		press(B_MODE);
		press(B_POS);	// hours back to seconds
		set_to(10);
		press(B_POS);
		set_to(2);
		press(B_ALARM);
		press(B_MODE);
		wait_alarm();
		wait_time(0, 2, 15, "alarm hold until 00:02:15");
		press(B_ALARM);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
design/clock_pkg.sv
design/seg_pkg.sv
design/field_if.sv
design/tick_gen.sv
design/mode_ctrl.sv
design/time_field.sv
design/display_scan.sv
design/clock_top.sv
tb/tb_clock_top.sv
